// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tapeFormatterTb
FILELIST  = sim.f
BUILD_DIR = obj_dir
SIM_ARGS  = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== design/tapeBusPort.sv ====
`timescale 1ns/1ps

module tapeBusPort #(
   parameter logic [2:0]  driveUnit = 3'd0,
   parameter logic [2:0]  drvNum    = 3'd0,
   parameter logic [15:0] drvType   = tapePkg::defDrvType,
   parameter logic [15:0] drvSerial = tapePkg::defDrvSerial
) (
   input  tapePkg::mbReq_t  req,
   input  logic [15:0]      cs1,
   input  logic [15:0]      fc,
   input  logic [15:0]      mr,
   input  logic [15:0]      tc,
   input  logic [15:0]      ds,
   input  logic [15:0]      er,
   output tapePkg::regWr_t  wr,
   output tapePkg::cmdEvt_t evt,
   output logic [15:0]      readData
);

   import tapePkg::*;

   logic        selected;
   logic [15:0] wData;
   logic [4:0]  fun;
   logic        wrCs1Sel;
   logic        wrFcSel;
   logic        wrMrSel;
   logic        wrTcSel;
   logic        wrAsSel;
   logic        goReq;
   logic        funLegal;
   logic [15:0] asWord;

   // Legal function table
   function automatic logic isLegalFun(input logic [4:0] code);
      logic legal;
      case (code)
         nop, unload, rewind, drvClr, preset, erase, wrTapeMark,
         spcFwd, spcRev, wrChkFwd, wrChkRev, wrFwd, rdFwd, rdRev:
            legal = 1'b1;
         default:
            legal = 1'b0;
      endcase
      return legal;
   endfunction

   // Only our unit number answers
   assign selected = (req.unit == driveUnit);
   // Register data lives in the low half-word
   assign wData    = req.data[15:0];
   assign fun      = wData[cs1FunLsb +: 5];

   //////////////////////////////
   // Write decode
   //////////////////////////////

   assign wrCs1Sel = req.write & selected & (req.regSel == regCs1);
   assign wrFcSel  = req.write & selected & (req.regSel == regFc);
   assign wrMrSel  = req.write & selected & (req.regSel == regMr);
   assign wrTcSel  = req.write & selected & (req.regSel == regTc);
   assign wrAsSel  = req.write & selected & (req.regSel == regAs);

   // GO with good parity
   assign goReq    = wrCs1Sel & wData[cs1GoBit] & ~req.parityTest;
   assign funLegal = isLegalFun(fun);

   always_comb begin
      wr        = '0;
      // Bad-parity GO is thrown away, function field untouched
      wr.wrCs1  = wrCs1Sel & ~(wData[cs1GoBit] & req.parityTest);
      wr.wrFc   = wrFcSel;
      wr.wrMr   = wrMrSel;
      wr.wrTc   = wrTcSel;
      // Parity test on FC, MR, TC flags PAR
      wr.setPar = req.parityTest & (wrFcSel | wrMrSel | wrTcSel);
      wr.setIlf = goReq & ~funLegal;
   end

   always_comb begin
      evt        = '0;
      evt.go     = goReq & funLegal;
      evt.drvClr = goReq & (fun == drvClr);
      // Our bit in the attention summary
      evt.clrAta = wrAsSel & wData[drvNum];
   end

   //////////////////////////////
   // Read mux
   //////////////////////////////

   // AS carries only our own ATA bit
   always_comb begin
      asWord         = '0;
      asWord[drvNum] = ds[dsAtaBit];
   end

   always_comb begin
      readData = '0;
      if (req.read & selected) begin
         case (req.regSel)
            regCs1:  readData = cs1;
            regDs:   readData = ds;
            regEr:   readData = er;
            regMr:   readData = mr;
            regAs:   readData = asWord;
            regFc:   readData = fc;
            regDt:   readData = drvType;
            regSn:   readData = drvSerial;
            regTc:   readData = tc;
            default: readData = '0;
         endcase
      end
   end

endmodule

// ==== design/tapeCtrlRegs.sv ====
`timescale 1ns/1ps

module tapeCtrlRegs (
   input  logic            clk,
   input  logic            rst,
   input  logic            init,
   input  logic [15:0]     data,
   input  tapePkg::regWr_t wr,
   output logic [15:0]     cs1,
   output logic [15:0]     fc,
   output logic [15:0]     mr,
   output logic [15:0]     tc,
   output logic            invertParity
);

   import tapePkg::*;

   logic [4:0]  funReg;
   logic [15:0] fcReg;
   logic [15:0] mrReg;
   logic [15:0] tcReg;
   logic        invParReg;
   logic        evenParSel;

   // Maintenance mode with even parity op
   assign evenParSel = data[mrMmBit] & (data[mrOpLsb +: 3] == mrOpEvenPar);

   always_ff @(posedge clk) begin
      if (rst) begin
         funReg    <= '0;
         fcReg     <= '0;
         mrReg     <= '0;
         tcReg     <= '0;
         invParReg <= 1'b0;
      end else begin
         if (wr.wrCs1)
            funReg <= data[cs1FunLsb +: 5];
         if (wr.wrFc)
            fcReg <= data;
         // Parity inversion tracks the new MR value
         if (wr.wrMr) begin
            mrReg     <= data;
            invParReg <= evenParSel;
         end
         // Init wipes TC, FCS included
         if (init) begin
            tcReg <= '0;
         end else if (wr.wrTc) begin
            tcReg           <= data;
            tcReg[tcFcsBit] <= tcReg[tcFcsBit];
         end else if (wr.wrFc) begin
            tcReg[tcFcsBit] <= 1'b1;
         end
      end
   end

   // CS1 image
   always_comb begin
      cs1                 = '0;
      cs1[cs1FunLsb +: 5] = funReg;
      cs1[cs1GoBit]       = 1'b0;     // GO never sticks
      cs1[cs1DvaBit]      = 1'b1;
   end

   assign fc           = fcReg;
   assign mr           = mrReg;
   assign tc           = tcReg;
   assign invertParity = invParReg;

endmodule

// ==== design/tapeDriveStatus.sv ====
`timescale 1ns/1ps

module tapeDriveStatus (
   input  logic             clk,
   input  logic             rst,
   input  logic             init,
   input  tapePkg::regWr_t  wr,
   input  tapePkg::cmdEvt_t evt,
   input  logic             mol,
   input  logic             wrl,
   input  logic             dpr,
   output logic [15:0]      ds,
   output logic [15:0]      er,
   output logic             attention
);

   import tapePkg::*;

   logic ilfErr;
   logic parErr;
   logic ataReg;
   logic errAny;
   logic errClr;
   logic ataSet;
   logic ataClr;

   //////////////////////////////
   // Error register
   //////////////////////////////

   // Drive clear and init both reset the error bits
   assign errClr = evt.drvClr | init;

   always_ff @(posedge clk) begin
      if (rst) begin
         ilfErr <= 1'b0;
         parErr <= 1'b0;
      end else begin
         if (wr.setIlf)
            ilfErr <= 1'b1;
         else if (errClr)
            ilfErr <= 1'b0;
         if (wr.setPar)
            parErr <= 1'b1;
         else if (errClr)
            parErr <= 1'b0;
      end
   end

   always_comb begin
      er           = '0;
      er[erIlfBit] = ilfErr;
      er[erParBit] = parErr;
   end

   assign errAny = |er;

   //////////////////////////////
   // Attention
   //////////////////////////////

   // New error raises ATA
   assign ataSet = wr.setIlf | wr.setPar;
   // AS write, clean legal GO, drive clear, init
   assign ataClr = evt.clrAta | (evt.go & ~errAny) | evt.drvClr | init;

   // Set beats clear
   always_ff @(posedge clk) begin
      if (rst)
         ataReg <= 1'b0;
      else if (ataSet)
         ataReg <= 1'b1;
      else if (ataClr)
         ataReg <= 1'b0;
   end

   // Drive status word
   always_comb begin
      ds           = '0;
      ds[dsAtaBit] = ataReg;
      ds[dsErrBit] = errAny;
      ds[dsMolBit] = mol;
      ds[dsWrlBit] = wrl;
      ds[dsDprBit] = dpr;
      ds[dsDryBit] = 1'b1;        // no motion, always ready
   end

   assign attention = ataReg;

endmodule

// ==== design/tapeFormatter.sv ====
`timescale 1ns/1ps

module tapeFormatter #(
   parameter logic [2:0]  driveUnit = 3'd0,
   parameter logic [2:0]  drvNum    = 3'd0,
   parameter logic [15:0] drvType   = tapePkg::defDrvType,
   parameter logic [15:0] drvSerial = tapePkg::defDrvSerial
) (
   input  logic            clk,
   input  logic            rst,
   input  tapePkg::mbReq_t req,
   input  logic [7:0]      mol,
   input  logic [7:0]      wrl,
   input  logic [7:0]      dpr,
   output logic [15:0]     readData,
   output logic            attention,
   output logic            invertParity
);

   import tapePkg::*;

   regWr_t      wr;
   cmdEvt_t     evt;
   logic [15:0] cs1;
   logic [15:0] fc;
   logic [15:0] mr;
   logic [15:0] tc;
   logic [15:0] ds;
   logic [15:0] er;

   // Bus decode and readback
   tapeBusPort #(
      .driveUnit (driveUnit),
      .drvNum    (drvNum),
      .drvType   (drvType),
      .drvSerial (drvSerial)
   ) busPort (
      .req      (req),
      .cs1      (cs1),
      .fc       (fc),
      .mr       (mr),
      .tc       (tc),
      .ds       (ds),
      .er       (er),
      .wr       (wr),
      .evt      (evt),
      .readData (readData)
   );

   // CS1, FC, MR, TC
   tapeCtrlRegs ctrlRegs (
      .clk          (clk),
      .rst          (rst),
      .init         (req.init),
      .data         (req.data[15:0]),
      .wr           (wr),
      .cs1          (cs1),
      .fc           (fc),
      .mr           (mr),
      .tc           (tc),
      .invertParity (invertParity)
   );

   // ER, DS, attention
   // Transport status picked by the unit on the bus
   tapeDriveStatus driveStatus (
      .clk       (clk),
      .rst       (rst),
      .init      (req.init),
      .wr        (wr),
      .evt       (evt),
      .mol       (mol[req.unit]),
      .wrl       (wrl[req.unit]),
      .dpr       (dpr[req.unit]),
      .ds        (ds),
      .er        (er),
      .attention (attention)
   );

endmodule

// ==== design/tapePkg.sv ====
package tapePkg;

   //////////////////////////////
   // Massbus register numbers
   //////////////////////////////

   typedef enum logic [4:0] {
      regCs1 = 5'o00,
      regDs  = 5'o01,
      regEr  = 5'o02,
      regMr  = 5'o03,
      regAs  = 5'o04,
      regFc  = 5'o05,
      regDt  = 5'o06,
      regSn  = 5'o10,
      regTc  = 5'o11
   } regAddr_t;

   // Legal TM03 function codes, anything else is illegal
   typedef enum logic [4:0] {
      nop        = 5'o00,
      unload     = 5'o01,
      rewind     = 5'o03,
      drvClr     = 5'o04,
      preset     = 5'o10,
      erase      = 5'o12,
      wrTapeMark = 5'o13,
      spcFwd     = 5'o14,
      spcRev     = 5'o15,
      wrChkFwd   = 5'o24,
      wrChkRev   = 5'o27,
      wrFwd      = 5'o30,
      rdFwd      = 5'o34,
      rdRev      = 5'o37
   } tapeFun_t;

   //////////////////////////////
   // Bus and strobe bundles
   //////////////////////////////

   // One Massbus cycle as seen by the slave
   typedef struct packed {
      logic        read;
      logic        write;
      regAddr_t    regSel;
      logic [2:0]  unit;
      logic        parityTest;
      logic        init;
      logic [35:0] data;
   } mbReq_t;

   // Single-cycle write strobes
   typedef struct packed {
      logic wrCs1;
      logic wrFc;
      logic wrMr;
      logic wrTc;
      logic setPar;
      logic setIlf;
   } regWr_t;

   // Command events
   typedef struct packed {
      logic go;
      logic drvClr;
      logic clrAta;
   } cmdEvt_t;

   //////////////////////////////
   // Register bit positions
   //////////////////////////////

   localparam int cs1GoBit  = 0;
   localparam int cs1FunLsb = 1;
   localparam int cs1DvaBit = 11;

   localparam int dsAtaBit  = 15;
   localparam int dsErrBit  = 14;
   localparam int dsMolBit  = 12;
   localparam int dsWrlBit  = 11;
   localparam int dsDprBit  = 8;
   localparam int dsDryBit  = 7;

   localparam int erIlfBit  = 0;
   localparam int erParBit  = 3;

   localparam int tcFcsBit  = 12;
   localparam int tcSsLsb   = 0;

   localparam int mrMmBit   = 0;
   localparam int mrOpLsb   = 1;

   // Even parity maintenance op
   localparam logic [2:0] mrOpEvenPar = 3'd1;

   // TM03 formatter with TU77 transport
   localparam logic [15:0] defDrvType   = 16'o142054;
   localparam logic [15:0] defDrvSerial = 16'o000001;

endpackage

// ==== sim.f ====
design/tapePkg.sv
design/tapeBusPort.sv
design/tapeCtrlRegs.sv
design/tapeDriveStatus.sv
design/tapeFormatter.sv
sim/tapeFormatter_assertions.sv
sim/tapeFormatterTb.sv

// ==== sim/tapeFormatterTb.sv ====
`timescale 1ns/1ps

module tapeFormatterTb;

   import tapePkg::*;

   localparam int waitLimit = 20;
   localparam int runLimit  = 2000;
   // All 5-bit codes outside the legal table
   localparam logic [4:0] illegalCodes [18] = '{
      5'o02, 5'o05, 5'o06, 5'o07, 5'o11, 5'o16, 5'o17, 5'o20, 5'o21,
      5'o22, 5'o23, 5'o25, 5'o26, 5'o31, 5'o32, 5'o33, 5'o35, 5'o36
   };

   logic        clk;
   logic        rst;
   mbReq_t      req;
   logic [7:0]  mol;
   logic [7:0]  wrl;
   logic [7:0]  dpr;
   logic [15:0] readData;
   logic        attention;
   logic        invertParity;
   logic [31:0] rnd;
   int          idx;

   tapeFormatter #(
      .driveUnit (3'd0),
      .drvNum    (3'd0)
   ) uut (
      .clk          (clk),
      .rst          (rst),
      .req          (req),
      .mol          (mol),
      .wrl          (wrl),
      .dpr          (dpr),
      .readData     (readData),
      .attention    (attention),
      .invertParity (invertParity)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   //////////////////////////////
   // Bus tasks
   //////////////////////////////

   task automatic abortRun(input string why);
      $display("tests failed");
      $fatal(1, "%s", why);
   endtask

   task automatic idleCycle();
      @(negedge clk);
      req = '0;
   endtask

   task automatic writeReg(input regAddr_t r, input logic [2:0] unit,
                           input logic pt, input logic [15:0] d);
      @(negedge clk);
      req            = '0;
      req.write      = 1'b1;
      req.regSel     = r;
      req.unit       = unit;
      req.parityTest = pt;
      req.data       = {20'b0, d};
   endtask

   task automatic readReg(input regAddr_t r, input logic [2:0] unit);
      @(negedge clk);
      req        = '0;
      req.read   = 1'b1;
      req.regSel = r;
      req.unit   = unit;
   endtask

   // New transport pins with a DS read in the same cycle
   task automatic readDsWith(input logic [31:0] pins);
      @(negedge clk);
      mol        = pins[7:0];
      wrl        = pins[15:8];
      dpr        = pins[23:16];
      req        = '0;
      req.read   = 1'b1;
      req.regSel = regDs;
   endtask

   task automatic initPulse();
      @(negedge clk);
      req      = '0;
      req.init = 1'b1;
   endtask

   task automatic waitAttention(input logic level);
      int n;
      n = 0;
      while ((attention !== level) && (n < waitLimit)) begin
         idleCycle();
         n++;
      end
      if (attention !== level)
         abortRun("attention never reached the expected level");
   endtask

   function automatic logic [15:0] goWord(input logic [4:0] f);
      return {10'b0, f, 1'b1};
   endfunction

   // Checker failure ends the run
   always @(negedge clk) begin
      if (uut.chk.failCount != 0)
         abortRun("bound checker reported an assertion failure");
   end

   initial begin
      repeat (runLimit) @(posedge clk);
      abortRun("simulation ran past its cycle limit");
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   initial begin
      rnd = $urandom(32'hfbf7fc1f);
      rst = 1'b1;
      req = '0;
      mol = 8'h00;
      wrl = 8'h00;
      dpr = 8'h00;
      idx = 0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Writable registers with FC ahead of TC to raise FCS
      for (int i = 0; i < 8; i++) begin
         rnd = $urandom();
         writeReg(regFc, 3'd0, 1'b0, rnd[15:0]);
         readReg(regFc, 3'd0);
         writeReg(regMr, 3'd0, 1'b0, rnd[31:16]);
         readReg(regMr, 3'd0);
         rnd = $urandom();
         writeReg(regTc, 3'd0, 1'b0, rnd[15:0]);
         readReg(regTc, 3'd0);
         // Foreign unit write leaves ours alone
         writeReg(regFc, rnd[18:16] | 3'd1, 1'b0, rnd[31:16]);
         readReg(regFc, 3'd0);
         readReg(regFc, rnd[18:16] | 3'd1);
      end

      // Illegal GO raises ILF and attention
      rnd = $urandom();
      idx = int'(rnd % 32'd18);
      writeReg(regCs1, 3'd0, 1'b0, goWord(illegalCodes[idx]));
      waitAttention(1'b1);
      readReg(regEr, 3'd0);
      readReg(regDs, 3'd0);
      readReg(regCs1, 3'd0);
      readReg(regAs, 3'd0);
      // AS without our bit and then with it
      writeReg(regAs, 3'd0, 1'b0, 16'h00fe);
      readReg(regAs, 3'd0);
      writeReg(regAs, 3'd0, 1'b0, 16'h0001);
      waitAttention(1'b0);
      readReg(regEr, 3'd0);

      // Drive clear drops ER and attention
      writeReg(regCs1, 3'd0, 1'b0, goWord(illegalCodes[(idx + 5) % 18]));
      waitAttention(1'b1);
      writeReg(regCs1, 3'd0, 1'b0, goWord(drvClr));
      waitAttention(1'b0);
      readReg(regEr, 3'd0);
      // Clean legal GO keeps attention low
      writeReg(regCs1, 3'd0, 1'b0, goWord(rdFwd));
      idleCycle();
      readReg(regCs1, 3'd0);

      // Parity test on FC flags PAR
      writeReg(regFc, 3'd0, 1'b1, 16'h1234);
      waitAttention(1'b1);
      readReg(regEr, 3'd0);
      writeReg(regCs1, 3'd0, 1'b0, goWord(drvClr));
      waitAttention(1'b0);
      // Bad-parity illegal GO is dropped
      writeReg(regCs1, 3'd0, 1'b1, goWord(illegalCodes[idx]));
      idleCycle();
      readReg(regEr, 3'd0);
      readReg(regCs1, 3'd0);

      // Transport pins and constants
      for (int i = 0; i < 6; i++) begin
         rnd = $urandom();
         readDsWith(rnd);
      end
      readReg(regDt, 3'd0);
      readReg(regSn, 3'd0);

      // Maintenance even parity on and off again
      writeReg(regMr, 3'd0, 1'b0, 16'h0003);
      idleCycle();
      writeReg(regMr, 3'd0, 1'b0, 16'h0005);
      idleCycle();
      writeReg(regMr, 3'd0, 1'b0, 16'h0003);
      writeReg(regMr, 3'd0, 1'b0, 16'h0002);
      idleCycle();

      // Parity error left pending for init
      writeReg(regTc, 3'd0, 1'b1, 16'h0a5a);
      waitAttention(1'b1);

      // Init wipes TC, ER and attention
      initPulse();
      waitAttention(1'b0);
      readReg(regEr, 3'd0);
      readReg(regTc, 3'd0);

      idleCycle();
      idleCycle();
      if (uut.chk.failCount == 0) begin
         $display("all tests passed");
         $finish;
      end else begin
         abortRun("bound checker reported an assertion failure");
      end
   end

endmodule

// ==== sim/tapeFormatter_assertions.sv ====
`timescale 1ns/1ps

module tapeFormatterChecker #(
   parameter logic [2:0] driveUnit = 3'd0,
   parameter logic [2:0] drvNum    = 3'd0
) (
   input logic            clk,
   input logic            rst,
   input tapePkg::mbReq_t req,
   input logic [7:0]      mol,
   input logic [7:0]      wrl,
   input logic [7:0]      dpr,
   input logic [15:0]     readData,
   input logic            attention,
   input logic            invertParity
);

   import tapePkg::*;

   // One bit per legal code: 00 01 03 04 10 12 13 14 15 24 27 30 34 37 octal
   localparam logic [31:0] legalMask = 32'h91903d1b;

   int          failCount = 0;
   logic        sel;
   logic        wrSel;
   logic [15:0] wData;
   logic [4:0]  fun;
   logic        goCmd;
   logic        goLegal;
   logic        setIlf;
   logic        setPar;
   logic        clrErr;
   logic        clrAta;
   logic        errM;
   logic [4:0]  funM;
   logic [15:0] fcM;
   logic [15:0] mrM;
   logic [15:0] tcM;
   logic        ilfM;
   logic        parM;
   logic        ataM;
   logic        invM;
   logic [15:0] expRd;

   //////////////////////////////
   // Reference model
   //////////////////////////////

   assign sel     = (req.unit == driveUnit);
   assign wrSel   = req.write && sel;
   assign wData   = req.data[15:0];
   assign fun     = wData[5:1];
   // GO without parity test
   assign goCmd   = wrSel && (req.regSel == regCs1) && wData[0] && !req.parityTest;
   assign goLegal = goCmd && legalMask[fun];
   assign setIlf  = goCmd && !legalMask[fun];
   assign setPar  = wrSel && req.parityTest && (req.regSel inside {regFc, regMr, regTc});
   assign errM    = ilfM | parM;
   // Drive clear is function 04
   assign clrErr  = (goLegal && (fun == 5'o04)) || req.init;
   assign clrAta  = clrErr || (goLegal && !errM) ||
                    (wrSel && (req.regSel == regAs) && wData[drvNum]);

   always_ff @(posedge clk) begin
      if (rst) begin
         funM <= '0;
         fcM  <= '0;
         mrM  <= '0;
         tcM  <= '0;
         ilfM <= 1'b0;
         parM <= 1'b0;
         ataM <= 1'b0;
         invM <= 1'b0;
      end else begin
         // Bad-parity GO leaves CS1 alone
         if (wrSel && (req.regSel == regCs1) && !(wData[0] && req.parityTest))
            funM <= fun;
         if (wrSel && (req.regSel == regFc))
            fcM <= wData;
         if (wrSel && (req.regSel == regMr)) begin
            mrM <= wData;
            invM <= wData[0] && (wData[3:1] == 3'd1);
         end
         // FCS in bit 12 only moves on FC write or init
         if (req.init)
            tcM <= '0;
         else if (wrSel && (req.regSel == regTc))
            tcM <= {wData[15:13], tcM[12], wData[11:0]};
         else if (wrSel && (req.regSel == regFc))
            tcM[12] <= 1'b1;
         ilfM <= setIlf | (ilfM & ~clrErr);
         parM <= setPar | (parM & ~clrErr);
         ataM <= setIlf | setPar | (ataM & ~clrAta);
      end
   end

   // Expected read value per register
   always_comb begin
      expRd = '0;
      case (req.regSel)
         regCs1:  expRd = {4'b0, 1'b1, 5'b0, funM, 1'b0};
         regDs:   expRd = {ataM, errM, 1'b0, mol[req.unit], wrl[req.unit], 2'b0,
                           dpr[req.unit], 1'b1, 7'b0};
         regEr:   expRd = {12'b0, parM, 2'b0, ilfM};
         regMr:   expRd = mrM;
         regAs:   expRd[drvNum] = ataM;
         regFc:   expRd = fcM;
         regDt:   expRd = 16'o142054;
         regSn:   expRd = 16'o000001;
         regTc:   expRd = tcM;
         default: expRd = '0;
      endcase
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   readback: assert property (@(posedge clk) disable iff (rst)
      (req.read && sel) |-> (readData == expRd))
      else begin
         failCount = failCount + 1;
         $error("FAILED readback reg %0o: expected %h, actual %h",
                $sampled(req.regSel), $sampled(expRd), $sampled(readData));
      end

   // Other units and idle cycles read zero
   quietRead: assert property (@(posedge clk) disable iff (rst)
      !(req.read && sel) |-> (readData == 16'h0000))
      else begin
         failCount = failCount + 1;
         $error("FAILED quiet read: expected 0000, actual %h", $sampled(readData));
      end

   ataLevel: assert property (@(posedge clk) disable iff (rst)
      attention == ataM)
      else begin
         failCount = failCount + 1;
         $error("FAILED attention: expected %b, actual %b",
                $sampled(ataM), $sampled(attention));
      end

   invLevel: assert property (@(posedge clk) disable iff (rst)
      invertParity == invM)
      else begin
         failCount = failCount + 1;
         $error("FAILED invert parity: expected %b, actual %b",
                $sampled(invM), $sampled(invertParity));
      end

endmodule

bind tapeFormatter tapeFormatterChecker #(
   .driveUnit (driveUnit),
   .drvNum    (drvNum)
) chk (
   .clk          (clk),
   .rst          (rst),
   .req          (req),
   .mol          (mol),
   .wrl          (wrl),
   .dpr          (dpr),
   .readData     (readData),
   .attention    (attention),
   .invertParity (invertParity)
);
